/* project.f */
common/video_ctrl_pkg.sv
hdl/wb_addr_decoder.sv
hdl/gpio_regs.sv
vsync_gen/vsync_gen_regs.sv
vsync_gen/vsync_gen_core.sv
hdl/video_ctrl_top.sv
verif/tb_properties.sv
verif/tb_checker.sv
verif/tb_top.sv

/* Makefile */
# Verilator flow for the video timing controller

VERILATOR ?= verilator

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module tb_top -f project.f

sim:
	$(VERILATOR) --binary --timing --assert --top-module tb_top -f project.f -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/golden_vectors.txt */
# op addr(byte) data sel exp ; R/W bus access, L led value in exp
# F: addr=de cycles per frame, data=hsync pulse, sel=pol (bit0 h, bit1 v), exp=vsync cycles; D: sel=pol
R 40011000 00000000 f 00000000
R 40011020 00000000 f 00000320
R 40011040 00000000 f 0000020d
R 40021000 00000000 f 00000000
R 40021004 00000000 f 00000000
L 00000000 00000000 0 00000000
W 40021000 0000000c f 00000000
W 40021004 0000000a f 00000000
L 00000000 00000000 0 00000008
R 40021008 00000000 f 00000008
W 40021004 00000005 2 00000000
R 40021004 00000000 f 0000000a
W 40021004 00000005 1 00000000
L 00000000 00000000 0 00000004
R 40030000 00000000 f 00000000
W 40030010 ffffffff f 00000000
R 40021004 00000000 f 00000005
W 40011020 00000014 f 00000000
W 40011024 00000004 f 00000000
W 40011028 0000000f f 00000000
W 4001102c 00000000 f 00000000
W 40011030 00000002 f 00000000
W 40011034 00000001 f 00000000
W 40011040 0000000c f 00000000
W 40011044 00000002 f 00000000
W 40011048 00000009 f 00000000
W 4001104c 00000000 f 00000000
W 40011050 00000001 f 00000000
W 40011054 00000000 f 00000000
R 40011020 00000000 f 00000014
R 40011040 00000000 f 0000000c
R 40011028 00000000 f 0000000f
W 40011000 00000001 f 00000000
F 00000060 00000003 1 00000028
W 40011028 0000000b f 00000000
F 00000040 00000003 1 00000028
W 40011000 00000000 f 00000000
D 00000000 00000000 1 00000000

/* verif/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

	import video_ctrl_pkg::*;

	logic       wb_clk_o;
	logic       rst_n_i;
	wb_adr_t    wb_adr_i;
	wb_dat_t    wb_dat_i;
	logic       wb_we_i;
	wb_sel_t    wb_sel_i;
	logic       wb_stb_i;
	wb_dat_t    wb_dat_o;
	logic       wb_ack_o;
	logic [3:0] led_o;
	logic       hsync_o;
	logic       vsync_o;
	logic       de_o;

	logic        chk_req;
	logic [7:0]  chk_op;
	logic [15:0] chk_test;
	logic [31:0] chk_addr;
	logic [31:0] chk_data;
	logic [3:0]  chk_sel;
	logic [31:0] chk_exp;
	logic        chk_done;
	int          pass_cnt;
	int          fail_cnt;

	logic [7:0]  op_q   [$];
	logic [31:0] addr_q [$];
	logic [31:0] data_q [$];
	logic [31:0] sel_q  [$];
	logic [31:0] exp_q  [$];

	int seed = 3954;
	int cycles = 0;
	int limit = 1000;
	bit load_err = 0;

	always #2 wb_clk_o = ~wb_clk_o;

	video_ctrl_top u_video_ctrl_top (
		.wb_clk_o (wb_clk_o), .rst_n_i (rst_n_i),
		.wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i), .wb_we_i (wb_we_i),
		.wb_sel_i (wb_sel_i), .wb_stb_i (wb_stb_i),
		.wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o),
		.led_o (led_o), .hsync_o (hsync_o), .vsync_o (vsync_o), .de_o (de_o)
	);

	tb_checker u_tb_checker (
		.wb_clk_o (wb_clk_o), .wb_stb_i (wb_stb_i), .wb_ack_o (wb_ack_o),
		.wb_dat_o (wb_dat_o), .led_o (led_o), .hsync_o (hsync_o),
		.vsync_o (vsync_o), .de_o (de_o),
		.req_i (chk_req), .op_i (chk_op), .test_i (chk_test),
		.addr_i (chk_addr), .data_i (chk_data), .sel_i (chk_sel), .exp_i (chk_exp),
		.done_o (chk_done), .pass_cnt_o (pass_cnt), .fail_cnt_o (fail_cnt)
	);

	// Run budget from vector count and the last programmed frame size
	task automatic load_vectors();
		int fd;
		int n;
		int htot;
		int vtot;
		int frames;
		string line;
		logic [7:0] op;
		logic [31:0] a, d, s, e;
		htot = 800;
		vtot = 525;
		frames = 0;
		fd = $fopen("verif/golden_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden vector file");
			load_err = 1;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%c %h %h %h %h", op, a, d, s, e);
					if (n == 5) begin
						op_q.push_back(op);
						addr_q.push_back(a);
						data_q.push_back(d);
						sel_q.push_back(s);
						exp_q.push_back(e);
						if (op == "W" && a == 32'h4001_1020) htot = int'(d[11:0]);
						if (op == "W" && a == 32'h4001_1040) vtot = int'(d[11:0]);
						if (op == "F") frames++;
					end
				end
			end
			$fclose(fd);
			limit = op_q.size() * 8 + 2 * htot * vtot * frames + 100;
		end
	endtask

	task automatic run_vector(input int i);
		@(posedge wb_clk_o);
		#1;
		chk_op = op_q[i];
		chk_test = 16'(i);
		chk_addr = addr_q[i];
		chk_data = data_q[i];
		chk_sel = sel_q[i][3:0];
		chk_exp = exp_q[i];
		if (op_q[i] == "R" || op_q[i] == "W") begin
			wb_adr_i = addr_q[i][31:2];
			wb_dat_i = data_q[i];
			wb_sel_i = sel_q[i][3:0];
			wb_we_i = (op_q[i] == "W");
			wb_stb_i = 1'b1;
		end
		chk_req = 1'b1;
		do @(posedge wb_clk_o); while (!chk_done);
		#1;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		chk_req = 1'b0;
		do @(posedge wb_clk_o); while (chk_done);
	endtask

	always @(posedge wb_clk_o) begin
		cycles++;
		if (cycles > limit) begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		wb_clk_o = 1'b0;
		rst_n_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_we_i = 1'b0;
		wb_sel_i = '0;
		wb_stb_i = 1'b0;
		chk_req = 1'b0;
		chk_op = 8'h0;
		chk_test = '0;
		chk_addr = '0;
		chk_data = '0;
		chk_sel = '0;
		chk_exp = '0;
		load_vectors();
		repeat (16) @(posedge wb_clk_o);
		#1;
		rst_n_i = 1'b1;
		for (int i = 0; i < op_q.size(); i++) begin
			run_vector(i);
		end
		$display("Tests run: %0d, passed: %0d, failed: %0d", op_q.size(), pass_cnt, fail_cnt);
		if (fail_cnt == 0 && !load_err && pass_cnt == op_q.size()) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
	input  wire        wb_clk_o,
	input  wire        wb_stb_i,
	input  wire        wb_ack_o,
	input  wire [31:0] wb_dat_o,
	input  wire [3:0]  led_o,
	input  wire        hsync_o,
	input  wire        vsync_o,
	input  wire        de_o,

	input  wire        req_i,
	input  wire [7:0]  op_i,
	input  wire [15:0] test_i,
	input  wire [31:0] addr_i,
	input  wire [31:0] data_i,
	input  wire [3:0]  sel_i,
	input  wire [31:0] exp_i,
	output logic       done_o,
	output int         pass_cnt_o,
	output int         fail_cnt_o
);

	task automatic record(input bit ok, input string what);
		if (ok) begin
			pass_cnt_o++;
			$display("test %0d: %s ok", test_i, what);
		end else begin
			fail_cnt_o++;
			$display("test %0d: %s FAILED", test_i, what);
		end
	endtask

	function automatic bit is_idle(input logic [3:0] pol);
		return !de_o && (hsync_o == ~pol[0]) && (vsync_o == ~pol[1]);
	endfunction

	// ----------------------------------------------------------
	//  One frame, from vsync leading edge to the next
	// ----------------------------------------------------------
	task automatic measure_frame();
		int  de_n;
		int  vs_n;
		int  run;
		int  bad_runs;
		int  cyc;
		int  pulses;
		int  start;
		int  gap;
		bit  found;
		bit  ok;
		logic prev_v;
		logic hpol;
		logic vpol;
		hpol = sel_i[0];
		vpol = sel_i[1];
		de_n = 0;
		vs_n = 0;
		run = 0;
		bad_runs = 0;
		cyc = 0;
		pulses = 0;
		start = 0;
		gap = 0;
		found = 0;
		prev_v = vsync_o;
		while (!found) begin
			@(negedge wb_clk_o);
			found = (vsync_o == vpol) && (prev_v != vpol);
			prev_v = vsync_o;
		end
		found = 0;
		while (!found) begin
			if (de_o) de_n++;
			if (vsync_o == vpol) vs_n++;
			if (hsync_o == hpol) begin
				// Pulse starts evenly spaced, one per line
				if (run == 0) begin
					if (pulses == 1) begin
						gap = cyc - start;
					end else if (pulses > 1 && cyc - start != gap) begin
						bad_runs++;
					end
					start = cyc;
					pulses++;
				end
				run++;
			end else if (run != 0) begin
				if (run != data_i) bad_runs++;
				run = 0;
			end
			cyc++;
			@(negedge wb_clk_o);
			found = (vsync_o == vpol) && (prev_v != vpol);
			prev_v = vsync_o;
		end
		ok = (de_n == addr_i) && (vs_n == exp_i) && (bad_runs == 0)
			&& (pulses > 1) && (cyc == pulses * gap);
		if (!ok) begin
			$display("error at %0t ns: de %0d exp %0d, vsync %0d exp %0d, bad hsync %0d, lines %0d",
				$time, de_n, addr_i, vs_n, exp_i, bad_runs, pulses);
		end
		record(ok, "frame shape");
	endtask

	task automatic check_disable();
		int settle;
		int bad;
		settle = 0;
		bad = 0;
		while (settle < 3 && !is_idle(sel_i)) begin
			@(negedge wb_clk_o);
			settle++;
		end
		repeat (50) begin
			if (!is_idle(sel_i)) bad++;
			@(negedge wb_clk_o);
		end
		if (bad != 0) begin
			$display("Outputs did not return to idle after disable (%0d active cycles)", bad);
		end
		record(bad == 0, "disable");
	endtask

	initial begin
		done_o = 1'b0;
		pass_cnt_o = 0;
		fail_cnt_o = 0;
		forever begin
			@(negedge wb_clk_o);
			if (!req_i) begin
				done_o = 1'b0;
			end else if (!done_o) begin
				case (op_i)
					"R": begin
						if (!(wb_stb_i && wb_ack_o)) begin
							$display("Read of %h was not acknowledged in its strobe cycle",
								addr_i);
						end else if (wb_dat_o !== exp_i) begin
							$display("error at %0t ns: read %h returned %h, expected %h",
								$time, addr_i, wb_dat_o, exp_i);
						end
						record(wb_stb_i && wb_ack_o && (wb_dat_o === exp_i), "read");
						done_o = 1'b1;
					end
					"W": begin
						if (!(wb_stb_i && wb_ack_o)) begin
							$display("Write to %h was not acknowledged in its strobe cycle",
								addr_i);
						end
						record(wb_stb_i && wb_ack_o, "write");
						done_o = 1'b1;
					end
					"L": begin
						if (led_o !== exp_i[3:0]) begin
							$display("error at %0t ns: led_o %h, expected %h",
								$time, led_o, exp_i[3:0]);
						end
						record(led_o === exp_i[3:0], "led port");
						done_o = 1'b1;
					end
					"F": begin
						measure_frame();
						done_o = 1'b1;
					end
					"D": begin
						check_disable();
						done_o = 1'b1;
					end
					default: begin
						$display("Unknown operation code in golden file at test %0d", test_i);
						fail_cnt_o++;
						done_o = 1'b1;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* verif/tb_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_properties (
	input wire                          wb_clk_o,
	input wire                          rst_n_i,
	input wire video_ctrl_pkg::wb_adr_t wb_adr_i,
	input wire                          wb_we_i,
	input wire                          wb_stb_i,
	input wire                          wb_ack_o,
	input wire                          enable_i,
	input wire                          de_o
);

	import video_ctrl_pkg::*;

	logic ctl_written;

	// Any host write to the CTL register
	always_ff @(posedge wb_clk_o) begin
		if (!rst_n_i) begin
			ctl_written <= 1'b0;
		end else if (wb_stb_i && wb_we_i && wb_adr_i == {VSGEN_PAGE, 10'h000}) begin
			ctl_written <= 1'b1;
		end
	end

	ack_needs_stb: assert property (@(posedge wb_clk_o) disable iff (!rst_n_i)
		wb_ack_o |-> wb_stb_i)
		else $error("acknowledge without strobe");

	// Output register adds one cycle after the counter state
	de_needs_enable: assert property (@(posedge wb_clk_o) disable iff (!rst_n_i)
		de_o |-> $past(enable_i, 2))
		else $error("data enable while generator disabled");

	de_low_until_ctl: assert property (@(posedge wb_clk_o) disable iff (!rst_n_i)
		!ctl_written |-> !de_o)
		else $error("data enable before any CTL write");

endmodule

bind video_ctrl_top tb_properties u_tb_properties (
	.wb_clk_o (wb_clk_o),
	.rst_n_i  (rst_n_i),
	.wb_adr_i (wb_adr_i),
	.wb_we_i  (wb_we_i),
	.wb_stb_i (wb_stb_i),
	.wb_ack_o (wb_ack_o),
	.enable_i (enable),
	.de_o     (de_o)
);

`default_nettype wire

/* hdl/video_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module video_ctrl_top #(
	parameter int                       PORT_WIDTH       = 4,
	parameter video_ctrl_pkg::pix_cnt_t INIT_HTOTAL      = 12'd800,
	parameter video_ctrl_pkg::pix_cnt_t INIT_HDISP_START = 12'd112,
	parameter video_ctrl_pkg::pix_cnt_t INIT_HDISP_END   = 12'd751,
	parameter video_ctrl_pkg::pix_cnt_t INIT_HSYNC_START = 12'd0,
	parameter video_ctrl_pkg::pix_cnt_t INIT_HSYNC_END   = 12'd95,
	parameter logic                     INIT_HSYNC_POL   = 1'b0,
	parameter video_ctrl_pkg::pix_cnt_t INIT_VTOTAL      = 12'd525,
	parameter video_ctrl_pkg::pix_cnt_t INIT_VDISP_START = 12'd12,
	parameter video_ctrl_pkg::pix_cnt_t INIT_VDISP_END   = 12'd491,
	parameter video_ctrl_pkg::pix_cnt_t INIT_VSYNC_START = 12'd0,
	parameter video_ctrl_pkg::pix_cnt_t INIT_VSYNC_END   = 12'd2,
	parameter logic                     INIT_VSYNC_POL   = 1'b0
) (
	input  wire                          wb_clk_o,
	input  wire                          rst_n_i,

	input  wire video_ctrl_pkg::wb_adr_t wb_adr_i,
	input  wire video_ctrl_pkg::wb_dat_t wb_dat_i,
	input  wire                          wb_we_i,
	input  wire video_ctrl_pkg::wb_sel_t wb_sel_i,
	input  wire                          wb_stb_i,
	output video_ctrl_pkg::wb_dat_t      wb_dat_o,
	output logic                         wb_ack_o,

	output logic [PORT_WIDTH-1:0]        led_o,
	output logic                         hsync_o,
	output logic                         vsync_o,
	output logic                         de_o
);

	import video_ctrl_pkg::*;

	logic     gpio_stb;
	logic     gpio_ack;
	wb_dat_t  gpio_dat;
	logic     vsg_stb;
	logic     vsg_ack;
	wb_dat_t  vsg_dat;

	// Register bank to counter core
	logic     enable;
	logic     frame_start;
	logic     hsync_pol;
	logic     vsync_pol;
	pix_cnt_t htotal;
	pix_cnt_t hdisp_start;
	pix_cnt_t hdisp_end;
	pix_cnt_t hsync_start;
	pix_cnt_t hsync_end;
	pix_cnt_t vtotal;
	pix_cnt_t vdisp_start;
	pix_cnt_t vdisp_end;
	pix_cnt_t vsync_start;
	pix_cnt_t vsync_end;

	// ----------------------------------------------------------
	//  Host bus decode
	// ----------------------------------------------------------

	wb_addr_decoder u_wb_addr_decoder (
		.wb_adr_i   (wb_adr_i),
		.wb_stb_i   (wb_stb_i),
		.gpio_dat_i (gpio_dat),
		.gpio_ack_i (gpio_ack),
		.vsg_dat_i  (vsg_dat),
		.vsg_ack_i  (vsg_ack),
		.gpio_stb_o (gpio_stb),
		.vsg_stb_o  (vsg_stb),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_o   (wb_ack_o)
	);

	// ----------------------------------------------------------
	//  LED port
	// ----------------------------------------------------------

	gpio_regs #(
		.PORT_WIDTH (PORT_WIDTH)
	) u_gpio_regs (
		.wb_clk_o  (wb_clk_o),
		.rst_n_i   (rst_n_i),
		.reg_idx_i (wb_adr_i[9:2]),
		.wb_dat_i  (wb_dat_i),
		.wb_we_i   (wb_we_i),
		.wb_sel_i  (wb_sel_i),
		.wb_stb_i  (gpio_stb),
		.wb_dat_o  (gpio_dat),
		.wb_ack_o  (gpio_ack),
		.port_o    (led_o)
	);

	// ----------------------------------------------------------
	//  Sync generator
	// ----------------------------------------------------------

	vsync_gen_regs #(
		.INIT_HTOTAL      (INIT_HTOTAL),
		.INIT_HDISP_START (INIT_HDISP_START),
		.INIT_HDISP_END   (INIT_HDISP_END),
		.INIT_HSYNC_START (INIT_HSYNC_START),
		.INIT_HSYNC_END   (INIT_HSYNC_END),
		.INIT_HSYNC_POL   (INIT_HSYNC_POL),
		.INIT_VTOTAL      (INIT_VTOTAL),
		.INIT_VDISP_START (INIT_VDISP_START),
		.INIT_VDISP_END   (INIT_VDISP_END),
		.INIT_VSYNC_START (INIT_VSYNC_START),
		.INIT_VSYNC_END   (INIT_VSYNC_END),
		.INIT_VSYNC_POL   (INIT_VSYNC_POL)
	) u_vsync_gen_regs (
		.wb_clk_o      (wb_clk_o),
		.rst_n_i       (rst_n_i),
		.reg_idx_i     (wb_adr_i[9:2]),
		.wb_dat_i      (wb_dat_i),
		.wb_we_i       (wb_we_i),
		.wb_sel_i      (wb_sel_i),
		.wb_stb_i      (vsg_stb),
		.wb_dat_o      (vsg_dat),
		.wb_ack_o      (vsg_ack),
		.frame_start_i (frame_start),
		.enable_o      (enable),
		.htotal_o      (htotal),
		.hdisp_start_o (hdisp_start),
		.hdisp_end_o   (hdisp_end),
		.hsync_start_o (hsync_start),
		.hsync_end_o   (hsync_end),
		.hsync_pol_o   (hsync_pol),
		.vtotal_o      (vtotal),
		.vdisp_start_o (vdisp_start),
		.vdisp_end_o   (vdisp_end),
		.vsync_start_o (vsync_start),
		.vsync_end_o   (vsync_end),
		.vsync_pol_o   (vsync_pol)
	);

	vsync_gen_core u_vsync_gen_core (
		.wb_clk_o      (wb_clk_o),
		.rst_n_i       (rst_n_i),
		.enable_i      (enable),
		.htotal_i      (htotal),
		.hdisp_start_i (hdisp_start),
		.hdisp_end_i   (hdisp_end),
		.hsync_start_i (hsync_start),
		.hsync_end_i   (hsync_end),
		.hsync_pol_i   (hsync_pol),
		.vtotal_i      (vtotal),
		.vdisp_start_i (vdisp_start),
		.vdisp_end_i   (vdisp_end),
		.vsync_start_i (vsync_start),
		.vsync_end_i   (vsync_end),
		.vsync_pol_i   (vsync_pol),
		.frame_start_o (frame_start),
		.hsync_o       (hsync_o),
		.vsync_o       (vsync_o),
		.de_o          (de_o)
	);

endmodule

`default_nettype wire

/* vsync_gen/vsync_gen_core.sv */
`timescale 1ns/1ps
`default_nettype none

module vsync_gen_core (
	input  wire                           wb_clk_o,
	input  wire                           rst_n_i,

	input  wire                           enable_i,
	input  wire video_ctrl_pkg::pix_cnt_t htotal_i,
	input  wire video_ctrl_pkg::pix_cnt_t hdisp_start_i,
	input  wire video_ctrl_pkg::pix_cnt_t hdisp_end_i,
	input  wire video_ctrl_pkg::pix_cnt_t hsync_start_i,
	input  wire video_ctrl_pkg::pix_cnt_t hsync_end_i,
	input  wire                           hsync_pol_i,
	input  wire video_ctrl_pkg::pix_cnt_t vtotal_i,
	input  wire video_ctrl_pkg::pix_cnt_t vdisp_start_i,
	input  wire video_ctrl_pkg::pix_cnt_t vdisp_end_i,
	input  wire video_ctrl_pkg::pix_cnt_t vsync_start_i,
	input  wire video_ctrl_pkg::pix_cnt_t vsync_end_i,
	input  wire                           vsync_pol_i,

	output logic                          frame_start_o,
	output logic                          hsync_o,
	output logic                          vsync_o,
	output logic                          de_o
);

	import video_ctrl_pkg::*;

	vsg_state_e state_q;
	pix_cnt_t   h_cnt_q;
	pix_cnt_t   v_cnt_q;
	logic       running;
	logic       h_last;
	logic       v_last;
	logic       h_sync_win;
	logic       v_sync_win;
	logic       disp_win;

	assign running = (state_q == VSG_RUN);
	assign h_last  = (h_cnt_q == htotal_i - pix_cnt_t'(1));
	assign v_last  = (v_cnt_q == vtotal_i - pix_cnt_t'(1));

	// First pixel of each frame
	assign frame_start_o = running && (h_cnt_q == '0) && (v_cnt_q == '0);

	// ----------------------------------------------------------
	//  Counters
	// ----------------------------------------------------------

	always_ff @(posedge wb_clk_o) begin
		if (!rst_n_i) begin
			state_q <= VSG_IDLE;
			h_cnt_q <= '0;
			v_cnt_q <= '0;
		end else begin
			case (state_q)
				VSG_IDLE: begin
					h_cnt_q <= '0;
					v_cnt_q <= '0;
					if (enable_i) begin
						state_q <= VSG_RUN;
					end
				end
				VSG_RUN: begin
					if (!enable_i) begin
						state_q <= VSG_IDLE;
						h_cnt_q <= '0;
						v_cnt_q <= '0;
					end else if (h_last) begin
						h_cnt_q <= '0;
						v_cnt_q <= v_last ? '0 : v_cnt_q + pix_cnt_t'(1);
					end else begin
						h_cnt_q <= h_cnt_q + pix_cnt_t'(1);
					end
				end
			endcase
		end
	end

	// ----------------------------------------------------------
	//  Output compare
	// ----------------------------------------------------------

	assign h_sync_win = (h_cnt_q >= hsync_start_i) && (h_cnt_q <= hsync_end_i);
	assign v_sync_win = (v_cnt_q >= vsync_start_i) && (v_cnt_q <= vsync_end_i);
	assign disp_win   = (h_cnt_q >= hdisp_start_i) && (h_cnt_q <= hdisp_end_i)
	                 && (v_cnt_q >= vdisp_start_i) && (v_cnt_q <= vdisp_end_i);

	always_ff @(posedge wb_clk_o) begin
		if (!rst_n_i) begin
			de_o    <= 1'b0;
			hsync_o <= ~hsync_pol_i;
			vsync_o <= ~vsync_pol_i;
		end else begin
			de_o    <= running && disp_win;
			// Inactive level is the inverse of the polarity bit
			hsync_o <= (running && h_sync_win) ? hsync_pol_i : ~hsync_pol_i;
			vsync_o <= (running && v_sync_win) ? vsync_pol_i : ~vsync_pol_i;
		end
	end

endmodule

`default_nettype wire

/* vsync_gen/vsync_gen_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module vsync_gen_regs #(
	parameter video_ctrl_pkg::pix_cnt_t INIT_HTOTAL      = 12'd800,
	parameter video_ctrl_pkg::pix_cnt_t INIT_HDISP_START = 12'd112,
	parameter video_ctrl_pkg::pix_cnt_t INIT_HDISP_END   = 12'd751,
	parameter video_ctrl_pkg::pix_cnt_t INIT_HSYNC_START = 12'd0,
	parameter video_ctrl_pkg::pix_cnt_t INIT_HSYNC_END   = 12'd95,
	parameter logic                     INIT_HSYNC_POL   = 1'b0,
	parameter video_ctrl_pkg::pix_cnt_t INIT_VTOTAL      = 12'd525,
	parameter video_ctrl_pkg::pix_cnt_t INIT_VDISP_START = 12'd12,
	parameter video_ctrl_pkg::pix_cnt_t INIT_VDISP_END   = 12'd491,
	parameter video_ctrl_pkg::pix_cnt_t INIT_VSYNC_START = 12'd0,
	parameter video_ctrl_pkg::pix_cnt_t INIT_VSYNC_END   = 12'd2,
	parameter logic                     INIT_VSYNC_POL   = 1'b0
) (
	input  wire                           wb_clk_o,
	input  wire                           rst_n_i,

	input  wire video_ctrl_pkg::reg_idx_t reg_idx_i,
	input  wire video_ctrl_pkg::wb_dat_t  wb_dat_i,
	input  wire                           wb_we_i,
	input  wire video_ctrl_pkg::wb_sel_t  wb_sel_i,
	input  wire                           wb_stb_i,
	output video_ctrl_pkg::wb_dat_t       wb_dat_o,
	output logic                          wb_ack_o,

	input  wire                           frame_start_i,
	output logic                          enable_o,
	output video_ctrl_pkg::pix_cnt_t      htotal_o,
	output video_ctrl_pkg::pix_cnt_t      hdisp_start_o,
	output video_ctrl_pkg::pix_cnt_t      hdisp_end_o,
	output video_ctrl_pkg::pix_cnt_t      hsync_start_o,
	output video_ctrl_pkg::pix_cnt_t      hsync_end_o,
	output logic                          hsync_pol_o,
	output video_ctrl_pkg::pix_cnt_t      vtotal_o,
	output video_ctrl_pkg::pix_cnt_t      vdisp_start_o,
	output video_ctrl_pkg::pix_cnt_t      vdisp_end_o,
	output video_ctrl_pkg::pix_cnt_t      vsync_start_o,
	output video_ctrl_pkg::pix_cnt_t      vsync_end_o,
	output logic                          vsync_pol_o
);

	import video_ctrl_pkg::*;

	localparam int         NUM_TIMING = 12;
	localparam logic [3:0] SLOT_NONE  = 4'hf;
	localparam logic [3:0] SLOT_HPOL  = 4'd5;
	localparam logic [3:0] SLOT_VPOL  = 4'd11;

	// Slots 0 to 5 horizontal, 6 to 11 vertical, same order as the register map
	localparam pix_cnt_t INIT_VAL [NUM_TIMING] = '{
		INIT_HTOTAL, INIT_HDISP_START, INIT_HDISP_END,
		INIT_HSYNC_START, INIT_HSYNC_END, pix_cnt_t'(INIT_HSYNC_POL),
		INIT_VTOTAL, INIT_VDISP_START, INIT_VDISP_END,
		INIT_VSYNC_START, INIT_VSYNC_END, pix_cnt_t'(INIT_VSYNC_POL)
	};

	function automatic logic [3:0] timing_slot(input reg_idx_t idx);
		case (idx)
			VSG_REG_HTOTAL:      return 4'd0;
			VSG_REG_HDISP_START: return 4'd1;
			VSG_REG_HDISP_END:   return 4'd2;
			VSG_REG_HSYNC_START: return 4'd3;
			VSG_REG_HSYNC_END:   return 4'd4;
			VSG_REG_HSYNC_POL:   return 4'd5;
			VSG_REG_VTOTAL:      return 4'd6;
			VSG_REG_VDISP_START: return 4'd7;
			VSG_REG_VDISP_END:   return 4'd8;
			VSG_REG_VSYNC_START: return 4'd9;
			VSG_REG_VSYNC_END:   return 4'd10;
			VSG_REG_VSYNC_POL:   return 4'd11;
			default:             return SLOT_NONE;
		endcase
	endfunction

	logic       ctl_q;
	pix_cnt_t   host_q [NUM_TIMING];
	pix_cnt_t   act_q  [NUM_TIMING];
	pix_cnt_t   act    [NUM_TIMING];
	logic [3:0] slot;
	logic       wr_en;
	wb_dat_t    rd_data;
	wb_dat_t    wr_val;
	pix_cnt_t   wr_field;

	assign slot  = timing_slot(reg_idx_i);
	assign wr_en = wb_stb_i && wb_we_i;

	// Readback always shows the host copy, not the active one
	always_comb begin
		rd_data = '0;
		if (reg_idx_i == VSG_REG_CTL) begin
			rd_data = wb_dat_t'(ctl_q);
		end else if (slot != SLOT_NONE) begin
			rd_data = wb_dat_t'(host_q[slot]);
		end
	end

	assign wr_val   = wb_merge(rd_data, wb_dat_i, wb_sel_i);
	assign wr_field = (slot == SLOT_HPOL || slot == SLOT_VPOL) ? pix_cnt_t'(wr_val[0])
	                                                             : wr_val[11:0];

	always_ff @(posedge wb_clk_o) begin
		if (!rst_n_i) begin
			ctl_q <= 1'b0;
			for (int i = 0; i < NUM_TIMING; i++) begin
				host_q[i] <= INIT_VAL[i];
				act_q[i]  <= INIT_VAL[i];
			end
		end else begin
			if (wr_en && reg_idx_i == VSG_REG_CTL) begin
				ctl_q <= wr_val[0];
			end
			if (wr_en && slot != SLOT_NONE) begin
				host_q[slot] <= wr_field;
			end
			// Frame boundary takes over the host values
			if (frame_start_i) begin
				act_q <= host_q;
			end
		end
	end

	// New values already apply in the frame-start cycle itself
	always_comb begin
		for (int i = 0; i < NUM_TIMING; i++) begin
			act[i] = frame_start_i ? host_q[i] : act_q[i];
		end
	end

	assign enable_o      = ctl_q;
	assign htotal_o      = act[0];
	assign hdisp_start_o = act[1];
	assign hdisp_end_o   = act[2];
	assign hsync_start_o = act[3];
	assign hsync_end_o   = act[4];
	assign hsync_pol_o   = act[5][0];
	assign vtotal_o      = act[6];
	assign vdisp_start_o = act[7];
	assign vdisp_end_o   = act[8];
	assign vsync_start_o = act[9];
	assign vsync_end_o   = act[10];
	assign vsync_pol_o   = act[11][0];

	assign wb_dat_o = rd_data;
	assign wb_ack_o = wb_stb_i;

endmodule

`default_nettype wire

/* hdl/gpio_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_regs #(
	parameter int PORT_WIDTH = 4
) (
	input  wire                           wb_clk_o,
	input  wire                           rst_n_i,

	input  wire video_ctrl_pkg::reg_idx_t reg_idx_i,
	input  wire video_ctrl_pkg::wb_dat_t  wb_dat_i,
	input  wire                           wb_we_i,
	input  wire video_ctrl_pkg::wb_sel_t  wb_sel_i,
	input  wire                           wb_stb_i,
	output video_ctrl_pkg::wb_dat_t       wb_dat_o,
	output logic                          wb_ack_o,

	output logic [PORT_WIDTH-1:0]         port_o
);

	import video_ctrl_pkg::*;

	logic [PORT_WIDTH-1:0] dir_q;
	logic [PORT_WIDTH-1:0] out_q;
	wb_dat_t               rd_data;
	wb_dat_t               wr_val;
	logic                  wr_en;

	// Pins not set as outputs are held low
	assign port_o = out_q & dir_q;

	always_comb begin
		case (reg_idx_i)
			GPIO_REG_DIR:  rd_data = wb_dat_t'(dir_q);
			GPIO_REG_OUT:  rd_data = wb_dat_t'(out_q);
			GPIO_REG_PORT: rd_data = wb_dat_t'(port_o);
			default:       rd_data = '0;
		endcase
	end

	assign wr_en  = wb_stb_i && wb_we_i;
	assign wr_val = wb_merge(rd_data, wb_dat_i, wb_sel_i);

	always_ff @(posedge wb_clk_o) begin
		if (!rst_n_i) begin
			dir_q <= '0;
			out_q <= '0;
		end else if (wr_en) begin
			if (reg_idx_i == GPIO_REG_DIR) begin
				dir_q <= wr_val[PORT_WIDTH-1:0];
			end
			if (reg_idx_i == GPIO_REG_OUT) begin
				out_q <= wr_val[PORT_WIDTH-1:0];
			end
		end
	end

	assign wb_dat_o = rd_data;
	assign wb_ack_o = wb_stb_i;

endmodule

`default_nettype wire

/* hdl/wb_addr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_addr_decoder (
	input  wire video_ctrl_pkg::wb_adr_t wb_adr_i,
	input  wire                          wb_stb_i,

	input  wire video_ctrl_pkg::wb_dat_t gpio_dat_i,
	input  wire                          gpio_ack_i,
	input  wire video_ctrl_pkg::wb_dat_t vsg_dat_i,
	input  wire                          vsg_ack_i,

	output logic                         gpio_stb_o,
	output logic                         vsg_stb_o,
	output video_ctrl_pkg::wb_dat_t      wb_dat_o,
	output logic                         wb_ack_o
);

	import video_ctrl_pkg::*;

	page_t page;

	// Upper address bits select the slave page
	assign page = wb_adr_i[31:12];

	assign gpio_stb_o = wb_stb_i && (page == GPIO_PAGE);
	assign vsg_stb_o  = wb_stb_i && (page == VSGEN_PAGE);

	// ----------------------------------------------------------
	//  Return path
	// ----------------------------------------------------------

	always_comb begin
		if (gpio_stb_o) begin
			wb_dat_o = gpio_dat_i;
			wb_ack_o = gpio_ack_i;
		end else if (vsg_stb_o) begin
			wb_dat_o = vsg_dat_i;
			wb_ack_o = vsg_ack_i;
		end else begin
			// Unmapped page answers at once with zero data
			wb_dat_o = '0;
			wb_ack_o = wb_stb_i;
		end
	end

endmodule

`default_nettype wire

/* common/video_ctrl_pkg.sv */
`default_nettype none

package video_ctrl_pkg;

	// ----------------------------------------------------------
	//  Bus and counter widths
	// ----------------------------------------------------------

	typedef logic [31:2] wb_adr_t;
	typedef logic [31:0] wb_dat_t;
	typedef logic [3:0]  wb_sel_t;
	typedef logic [7:0]  reg_idx_t;
	typedef logic [19:0] page_t;
	typedef logic [11:0] pix_cnt_t;

	// ----------------------------------------------------------
	//  Address map
	// ----------------------------------------------------------

	localparam page_t GPIO_PAGE  = 20'h40021;
	localparam page_t VSGEN_PAGE = 20'h40011;

	localparam reg_idx_t GPIO_REG_DIR  = 8'd0;
	localparam reg_idx_t GPIO_REG_OUT  = 8'd1;
	localparam reg_idx_t GPIO_REG_PORT = 8'd2;

	localparam reg_idx_t VSG_REG_CTL         = 8'd0;
	localparam reg_idx_t VSG_REG_HTOTAL      = 8'd8;
	localparam reg_idx_t VSG_REG_HDISP_START = 8'd9;
	localparam reg_idx_t VSG_REG_HDISP_END   = 8'd10;
	localparam reg_idx_t VSG_REG_HSYNC_START = 8'd11;
	localparam reg_idx_t VSG_REG_HSYNC_END   = 8'd12;
	localparam reg_idx_t VSG_REG_HSYNC_POL   = 8'd13;
	localparam reg_idx_t VSG_REG_VTOTAL      = 8'd16;
	localparam reg_idx_t VSG_REG_VDISP_START = 8'd17;
	localparam reg_idx_t VSG_REG_VDISP_END   = 8'd18;
	localparam reg_idx_t VSG_REG_VSYNC_START = 8'd19;
	localparam reg_idx_t VSG_REG_VSYNC_END   = 8'd20;
	localparam reg_idx_t VSG_REG_VSYNC_POL   = 8'd21;

	typedef enum logic {
		VSG_IDLE = 1'b0,
		VSG_RUN  = 1'b1
	} vsg_state_e;

	// Byte-lane merge of write data into the current register value
	function automatic wb_dat_t wb_merge(input wb_dat_t old_val, input wb_dat_t new_val,
			input wb_sel_t sel);
		wb_dat_t mask;
		for (int i = 0; i < 4; i++) begin
			mask[8*i +: 8] = {8{sel[i]}};
		end
		return (old_val & ~mask) | (new_val & mask);
	endfunction

endpackage

`default_nettype wire
